// ==== project.f ====
+incdir+verilog
verilog/isa_pkg.sv
verilog/mem_pkg.sv
verilog/register_file.sv
verilog/alu.sv
verilog/hazard_unit.sv
verilog/memory_arbiter.sv
verilog/datapath.sv
verilog/cpu_system.sv
tb/cpu_system_checker.sv
tb/cpu_system_tb.sv

// ==== tb/cpu_system_tb.sv ====
// Testbench: clock, reset, random program, variable-latency memory, ISA reference model, checks
`timescale 1ns/1ps
`include "cpu_consts.svh"

module cpu_system_tb;
  import isa_pkg::*;

  localparam int MEM_WORDS      = 256;
  localparam int DATA_BASE      = 128;
  localparam int DATA_WORDS     = 16;
  localparam int PROG_LEN       = 60;
  // Instructions x accesses per instruction x worst cycles per access
  localparam int TIMEOUT_CYCLES = PROG_LEN * 4 * 6;

  logic  CLK       = 1'b0;
  logic  nRST      = 1'b0;
  word_t ram_load  = '0;
  logic  ram_ready = 1'b0;
  logic  ram_ren, ram_wen, halt;
  word_t ram_addr, ram_store;

  word_t mem [MEM_WORDS];
  word_t ref_mem [MEM_WORDS];
  word_t exp_addr [$];
  word_t exp_data [$];
  int    store_cnt = 0;
  int    wait_left = 1;
  int    cycle_cnt = 0;

  cpu_system dut (
    .CLK       (CLK),
    .nRST      (nRST),
    .ram_ren   (ram_ren),
    .ram_wen   (ram_wen),
    .ram_addr  (ram_addr),
    .ram_store (ram_store),
    .ram_load  (ram_load),
    .ram_ready (ram_ready),
    .halt      (halt)
  );

  initial begin
    forever #2 CLK = ~CLK;
  end

  task automatic stop_with_failure(input string why);
    $display("%s", why);
    $display("FAIL: see errors above");
    $fatal(1, "simulation stopped on the first error");
  endtask

  task automatic check_eq(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
      stop_with_failure($sformatf("[FAIL] %s: got 0x%08h, expected 0x%08h", name, got, exp));
    end
  endtask

  function automatic word_t encode_rtype(funct_t fn, regbits_t rd, regbits_t rs, regbits_t rt);
    return {RTYPE, rs, rt, rd, 5'd0, fn};
  endfunction

  function automatic word_t encode_itype(opcode_t op, regbits_t rt, regbits_t rs,
                                         logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  function automatic word_t encode_jump(int target_idx);
    return {J, 26'(target_idx)};
  endfunction

  // Byte offset of a random word in the data region, based on register zero
  function automatic logic [15:0] data_offset();
    return 16'(DATA_BASE * 4 + 4 * ($urandom % DATA_WORDS));
  endfunction

  task automatic build_program();
    funct_t      fn_list [5];
    int          kind;
    int          off;
    int          max_off;
    int          load_rt;
    regbits_t    rs, rt, rd;
    logic [15:0] imm;
    fn_list = '{ADDU, SUBU, AND, OR, SLT};
    load_rt = -1;
    for (int a = 0; a < MEM_WORDS; a++) begin
      mem[a] = 32'h6C3A_0000 ^ (a * 32'h0107_0B0D);
    end
    for (int i = 0; i < PROG_LEN - 1; i++) begin
      kind = $urandom % 16;
      rs   = regbits_t'($urandom % 8);
      rt   = regbits_t'($urandom % 8);
      rd   = regbits_t'($urandom % 8);
      imm  = 16'($urandom);
      // Forward targets stop at the HALT word
      max_off = PROG_LEN - 2 - i;
      off     = $urandom % 4;
      if (off > max_off) begin
        off = max_off;
      end
      // Reader right after a load gets the load-use stall
      if (load_rt >= 0) begin
        rs = regbits_t'(load_rt);
      end
      load_rt = -1;
      case (kind)
        0, 1, 2, 3, 4: mem[i] = encode_rtype(fn_list[$urandom % 5], rd, rs, rt);
        5:             mem[i] = encode_itype(ADDIU, rt, rs, imm);
        6:             mem[i] = encode_itype(ORI, rt, rs, imm);
        7:             mem[i] = encode_itype(LUI, rt, 5'd0, imm);
        8, 9: begin
          mem[i]  = encode_itype(LW, rt, 5'd0, data_offset());
          load_rt = int'(rt);
        end
        10, 11, 12:    mem[i] = encode_itype(SW, rt, 5'd0, data_offset());
        13:            mem[i] = encode_itype(BEQ, rt, rs, 16'(off));
        14:            mem[i] = encode_itype(BNE, rt, rs, 16'(off));
        default:       mem[i] = encode_jump(i + 1 + off);
      endcase
    end
    mem[PROG_LEN - 1] = `HALT_WORD;
  endtask

  // Sequential interpreter of the same program
  task automatic run_reference_model();
    word_t regs [`REG_COUNT];
    word_t pc, instr, a, b, sext, zext, addr;
    bit    done;
    regs = '{default: '0};
    pc   = `PC_INIT;
    done = 1'b0;
    for (int steps = 0; steps < PROG_LEN && !done; steps++) begin
      instr = ref_mem[pc[9:2]];
      a     = regs[instr[25:21]];
      b     = regs[instr[20:16]];
      sext  = {{16{instr[15]}}, instr[15:0]};
      zext  = {16'h0000, instr[15:0]};
      addr  = a + sext;
      pc    = pc + 32'd4;
      if (instr == `HALT_WORD) begin
        done = 1'b1;
      end else begin
        case (opcode_t'(instr[31:26]))
          RTYPE: begin
            case (funct_t'(instr[5:0]))
              ADDU:    regs[instr[15:11]] = a + b;
              SUBU:    regs[instr[15:11]] = a - b;
              AND:     regs[instr[15:11]] = a & b;
              OR:      regs[instr[15:11]] = a | b;
              SLT:     regs[instr[15:11]] = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
              default: ;
            endcase
          end
          ADDIU: regs[instr[20:16]] = a + sext;
          ORI:   regs[instr[20:16]] = a | zext;
          LUI:   regs[instr[20:16]] = {instr[15:0], 16'h0000};
          LW:    regs[instr[20:16]] = ref_mem[addr[9:2]];
          SW: begin
            ref_mem[addr[9:2]] = b;
            exp_addr.push_back(addr);
            exp_data.push_back(b);
          end
          BEQ:   if (a == b) pc = pc + {sext[29:0], 2'b00};
          BNE:   if (a != b) pc = pc + {sext[29:0], 2'b00};
          J:     pc = {pc[31:28], instr[25:0], 2'b00};
          default: ;
        endcase
      end
      regs[0] = '0;
    end
  endtask

  // Each completed store must be the model's next one
  task automatic record_store(input word_t addr, input word_t data);
    if (store_cnt >= exp_addr.size()) begin
      stop_with_failure($sformatf("Store number %0d to address 0x%08h is one more than expected",
                                  store_cnt + 1, addr));
    end else begin
      check_eq("ram_addr", addr, exp_addr[store_cnt]);
      check_eq("ram_store", data, exp_data[store_cnt]);
      store_cnt++;
    end
  endtask

  // Memory with a random wait of 1 to 4 cycles per access
  always @(posedge CLK) begin
    if (!nRST) begin
      ram_ready <= 1'b0;
    end else if (ram_ready) begin
      ram_ready <= 1'b0;
    end else if (ram_ren || ram_wen) begin
      if (wait_left > 1) begin
        wait_left <= wait_left - 1;
      end else begin
        wait_left <= 1 + $urandom % 4;
        ram_ready <= 1'b1;
        if (ram_wen) begin
          record_store(ram_addr, ram_store);
          mem[ram_addr[9:2]] <= ram_store;
        end else begin
          ram_load <= mem[ram_addr[9:2]];
        end
      end
    end
  end

  always @(posedge CLK) begin
    if (nRST && !halt) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= TIMEOUT_CYCLES) begin
        stop_with_failure($sformatf("Timeout: halt did not rise within %0d cycles",
                                    TIMEOUT_CYCLES));
      end
    end
  end

  always @(negedge CLK) begin
    if (dut.u_checker.fail_count != 0) begin
      stop_with_failure("A port assertion in the bound checker failed");
    end
  end

  initial begin
    void'($urandom(61));
    build_program();
    ref_mem = mem;
    run_reference_model();
    repeat (16) begin
      @(negedge CLK);
      check_eq("ram_ren", ram_ren, 1'b0);
      check_eq("ram_wen", ram_wen, 1'b0);
      check_eq("halt", halt, 1'b0);
    end
    @(posedge CLK);
    nRST <= 1'b1;
    @(negedge CLK);
    check_eq("ram_ren", ram_ren, 1'b0);
    check_eq("ram_wen", ram_wen, 1'b0);
    check_eq("halt", halt, 1'b0);
    while (!ram_ren) begin
      @(negedge CLK);
    end
    check_eq("ram_addr", ram_addr, `PC_INIT);
    while (!halt) begin
      @(negedge CLK);
    end
    // All stores done by the time halt rises
    check_eq("store_count", word_t'(store_cnt), word_t'(exp_addr.size()));
    repeat (10) begin
      @(negedge CLK);
      check_eq("halt", halt, 1'b1);
    end
    check_eq("store_count", word_t'(store_cnt), word_t'(exp_addr.size()));
    for (int k = 0; k < DATA_WORDS; k++) begin
      check_eq($sformatf("mem[%0d]", DATA_BASE + k), mem[DATA_BASE + k],
               ref_mem[DATA_BASE + k]);
    end
    if (dut.u_checker.fail_count != 0) begin
      stop_with_failure("A port assertion in the bound checker failed");
    end else begin
      $display("PASS: all tests");
      $finish;
    end
  end

endmodule

// ==== tb/cpu_system_checker.sv ====
// Concurrent assertions on the RAM port handshake and the halt flag, bound into cpu_system
`timescale 1ns/1ps

module cpu_system_checker (
  input logic           CLK,
  input logic           nRST,
  input logic           ram_ren,
  input logic           ram_wen,
  input mem_pkg::addr_t ram_addr,
  input isa_pkg::word_t ram_store,
  input logic           ram_ready,
  input logic           halt
);
  int fail_count = 0;

  // Read and write never requested together
  a_one_dir: assert property (@(posedge CLK) disable iff (!nRST) !(ram_ren && ram_wen))
    else begin
      fail_count = fail_count + 1;
      $error("ram_ren and ram_wen are high in the same cycle");
    end

  // A waiting request keeps its level, address and store word
  a_req_stable: assert property (@(posedge CLK) disable iff (!nRST)
      (ram_ren || ram_wen) && !ram_ready |=>
      $stable(ram_ren) && $stable(ram_wen) && $stable(ram_addr) &&
      (!ram_wen || $stable(ram_store)))
    else begin
      fail_count = fail_count + 1;
      $error("RAM request changed before ram_ready");
    end

  // Nothing new starts once halted
  a_quiet_after_halt: assert property (@(posedge CLK) disable iff (!nRST)
      halt |-> !$rose(ram_ren) && !$rose(ram_wen))
    else begin
      fail_count = fail_count + 1;
      $error("RAM request raised after halt");
    end

  // Only reset clears halt
  a_halt_sticky: assert property (@(posedge CLK) disable iff (!nRST) halt |=> halt)
    else begin
      fail_count = fail_count + 1;
      $error("halt fell while reset was inactive");
    end

endmodule

bind cpu_system cpu_system_checker u_checker (
  .CLK       (CLK),
  .nRST      (nRST),
  .ram_ren   (ram_ren),
  .ram_wen   (ram_wen),
  .ram_addr  (ram_addr),
  .ram_store (ram_store),
  .ram_ready (ram_ready),
  .halt      (halt)
);

// ==== verilog/cpu_system.sv ====
// Processor top: datapath and memory arbiter on one external RAM port
`timescale 1ns/1ps

module cpu_system (
  input  logic           CLK,
  input  logic           nRST,
  output logic           ram_ren,
  output logic           ram_wen,
  output mem_pkg::addr_t ram_addr,
  output isa_pkg::word_t ram_store,
  input  isa_pkg::word_t ram_load,
  input  logic           ram_ready,
  output logic           halt
);
  import isa_pkg::*;
  import mem_pkg::*;

  // Instruction side
  logic  imem_ren, ihit;
  addr_t imem_addr;
  word_t imem_load;
  // Data side
  logic  dmem_ren, dmem_wen, dhit;
  addr_t dmem_addr;
  word_t dmem_store, dmem_load;

  datapath u_dp (
    .CLK        (CLK),
    .nRST       (nRST),
    .imem_ren   (imem_ren),
    .imem_addr  (imem_addr),
    .imem_load  (imem_load),
    .ihit       (ihit),
    .dmem_ren   (dmem_ren),
    .dmem_wen   (dmem_wen),
    .dmem_addr  (dmem_addr),
    .dmem_store (dmem_store),
    .dmem_load  (dmem_load),
    .dhit       (dhit),
    .halt       (halt)
  );

  memory_arbiter u_arb (
    .CLK        (CLK),
    .nRST       (nRST),
    .imem_ren   (imem_ren),
    .imem_addr  (imem_addr),
    .imem_load  (imem_load),
    .ihit       (ihit),
    .dmem_ren   (dmem_ren),
    .dmem_wen   (dmem_wen),
    .dmem_addr  (dmem_addr),
    .dmem_store (dmem_store),
    .dmem_load  (dmem_load),
    .dhit       (dhit),
    .ram_ren    (ram_ren),
    .ram_wen    (ram_wen),
    .ram_addr   (ram_addr),
    .ram_store  (ram_store),
    .ram_load   (ram_load),
    .ram_ready  (ram_ready)
  );

endmodule

// ==== verilog/datapath.sv ====
// Five-stage datapath with PC, stage registers, decoder, forwarding muxes, branch resolve, halt
`timescale 1ns/1ps
`include "cpu_consts.svh"

module datapath (
  input  logic           CLK,
  input  logic           nRST,
  output logic           imem_ren,
  output mem_pkg::addr_t imem_addr,
  input  isa_pkg::word_t imem_load,
  input  logic           ihit,
  output logic           dmem_ren,
  output logic           dmem_wen,
  output mem_pkg::addr_t dmem_addr,
  output isa_pkg::word_t dmem_store,
  input  isa_pkg::word_t dmem_load,
  input  logic           dhit,
  output logic           halt
);
  import isa_pkg::*;
  import mem_pkg::*;

  // Fetch and memory-wait bookkeeping
  addr_t    pc, pc_plus4;
  logic     i_done, d_done, mem_op, advance;
  word_t    ibuf, dbuf, fetched, load_word;
  // Fetch/decode
  word_t    ifid_instr;
  addr_t    ifid_npc;
  // Decode
  opcode_t  dc_op;
  funct_t   dc_fn;
  logic     dc_regwen, dc_memread, dc_memwrite, dc_alusrc;
  logic     dc_beq, dc_bne, dc_jump, dc_halt, dc_zext, dc_rw_rd;
  alu_op_t  dc_aluop;
  regbits_t dc_rs, dc_rt, dc_rw;
  word_t    dc_imm, rdat1, rdat2;
  // Decode/execute
  logic     idex_regwen, idex_memread, idex_memwrite, idex_alusrc;
  logic     idex_beq, idex_bne, idex_jump, idex_halt;
  alu_op_t  idex_aluop;
  regbits_t idex_rs, idex_rt, idex_rw;
  word_t    idex_rdat1, idex_rdat2, idex_imm;
  addr_t    idex_npc;
  logic [25:0] idex_jidx;
  // Execute
  fwd_sel_t fwd_a, fwd_b;
  word_t    opnd_a, opnd_b, alu_b, alu_out;
  logic     alu_zero, branch_taken, stall, flush;
  addr_t    target;
  // Execute/memory and memory/writeback
  logic     exmem_regwen, exmem_memread, exmem_memwrite, exmem_halt;
  regbits_t exmem_rw, memwb_rw;
  word_t    exmem_result, exmem_store, memwb_data;
  logic     memwb_regwen;

  // A completed half waits in its buffer for the other
  assign fetched   = i_done ? ibuf : imem_load;
  assign load_word = d_done ? dbuf : dmem_load;
  assign mem_op    = exmem_memread || exmem_memwrite;
  assign advance   = !halt && (ihit || i_done) && (!mem_op || dhit || d_done);
  assign pc_plus4  = pc + 32'd4;

  assign imem_ren   = !halt && !i_done;
  assign imem_addr  = pc;
  assign dmem_ren   = !halt && !d_done && exmem_memread;
  assign dmem_wen   = !halt && !d_done && exmem_memwrite;
  assign dmem_addr  = exmem_result;
  assign dmem_store = exmem_store;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      pc     <= `PC_INIT;
      i_done <= 1'b0;
      d_done <= 1'b0;
      halt   <= 1'b0;
    end else begin
      if (advance) begin
        if (flush) begin
          pc <= target;
        end else if (!stall) begin
          pc <= pc_plus4;
        end
        // On a stall the fetched word is kept for the repeat
        i_done <= stall;
        d_done <= 1'b0;
        if (exmem_halt) begin
          halt <= 1'b1;
        end
      end else begin
        if (ihit) i_done <= 1'b1;
        if (dhit) d_done <= 1'b1;
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (ihit) ibuf <= imem_load;
    if (dhit) dbuf <= dmem_load;
  end

  // Fetch/decode register holds all zeros as a bubble
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      ifid_instr <= '0;
    end else if (advance && flush) begin
      ifid_instr <= '0;
    end else if (advance && !stall) begin
      ifid_instr <= fetched;
    end
  end

  always_ff @(posedge CLK) begin
    if (advance && !stall) ifid_npc <= pc_plus4;
  end

  assign dc_rs  = ifid_instr[25:21];
  assign dc_rt  = ifid_instr[20:16];
  assign dc_rw  = dc_rw_rd ? ifid_instr[15:11] : dc_rt;
  assign dc_imm = dc_zext ? {16'h0000, ifid_instr[15:0]}
                          : {{16{ifid_instr[15]}}, ifid_instr[15:0]};

  always_comb begin
    dc_op       = opcode_t'(ifid_instr[31:26]);
    dc_fn       = funct_t'(ifid_instr[5:0]);
    dc_regwen   = 1'b0;
    dc_memread  = 1'b0;
    dc_memwrite = 1'b0;
    dc_alusrc   = 1'b0;
    dc_beq      = 1'b0;
    dc_bne      = 1'b0;
    dc_jump     = 1'b0;
    dc_halt     = 1'b0;
    dc_zext     = 1'b0;
    dc_rw_rd    = 1'b0;
    dc_aluop    = ALU_ADD;
    case (dc_op)
      RTYPE: begin
        dc_rw_rd  = 1'b1;
        dc_regwen = 1'b1;
        case (dc_fn)
          ADDU:    dc_aluop = ALU_ADD;
          SUBU:    dc_aluop = ALU_SUB;
          AND:     dc_aluop = ALU_AND;
          OR:      dc_aluop = ALU_OR;
          SLT:     dc_aluop = ALU_SLT;
          // Unknown funct, including the bubble word, does nothing
          default: dc_regwen = 1'b0;
        endcase
      end
      ADDIU: begin
        dc_regwen = 1'b1;
        dc_alusrc = 1'b1;
      end
      ORI: begin
        dc_regwen = 1'b1;
        dc_alusrc = 1'b1;
        dc_zext   = 1'b1;
        dc_aluop  = ALU_OR;
      end
      LUI: begin
        dc_regwen = 1'b1;
        dc_alusrc = 1'b1;
        dc_aluop  = ALU_LUI;
      end
      LW: begin
        dc_regwen  = 1'b1;
        dc_alusrc  = 1'b1;
        dc_memread = 1'b1;
      end
      SW: begin
        dc_alusrc   = 1'b1;
        dc_memwrite = 1'b1;
      end
      BEQ: begin
        dc_beq   = 1'b1;
        dc_aluop = ALU_SUB;
      end
      BNE: begin
        dc_bne   = 1'b1;
        dc_aluop = ALU_SUB;
      end
      J:       dc_jump = 1'b1;
      HALT:    dc_halt = (ifid_instr == `HALT_WORD);
      default: dc_regwen = 1'b0;
    endcase
  end

  register_file u_regs (
    .CLK   (CLK),
    .nRST  (nRST),
    .wen   (memwb_regwen),
    .wsel  (memwb_rw),
    .wdat  (memwb_data),
    .rsel1 (dc_rs),
    .rsel2 (dc_rt),
    .rdat1 (rdat1),
    .rdat2 (rdat2)
  );

  // Decode/execute register takes a bubble on a stall or flush
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      {idex_regwen, idex_memread, idex_memwrite, idex_alusrc} <= '0;
      {idex_beq, idex_bne, idex_jump, idex_halt} <= '0;
      idex_aluop <= ALU_ADD;
      {idex_rs, idex_rt, idex_rw} <= '0;
    end else if (advance && (stall || flush)) begin
      {idex_regwen, idex_memread, idex_memwrite, idex_alusrc} <= '0;
      {idex_beq, idex_bne, idex_jump, idex_halt} <= '0;
      idex_aluop <= ALU_ADD;
      {idex_rs, idex_rt, idex_rw} <= '0;
    end else if (advance) begin
      {idex_regwen, idex_memread, idex_memwrite, idex_alusrc} <=
        {dc_regwen, dc_memread, dc_memwrite, dc_alusrc};
      {idex_beq, idex_bne, idex_jump, idex_halt} <= {dc_beq, dc_bne, dc_jump, dc_halt};
      idex_aluop <= dc_aluop;
      {idex_rs, idex_rt, idex_rw} <= {dc_rs, dc_rt, dc_rw};
    end
  end

  always_ff @(posedge CLK) begin
    if (advance) begin
      idex_rdat1 <= rdat1;
      idex_rdat2 <= rdat2;
      idex_imm   <= dc_imm;
      idex_npc   <= ifid_npc;
      idex_jidx  <= ifid_instr[25:0];
    end
  end

  hazard_unit u_hazard (
    .rs_dc        (dc_rs),
    .rt_dc        (dc_rt),
    .rs_ex        (idex_rs),
    .rt_ex        (idex_rt),
    .rw_mem       (exmem_rw),
    .rw_wb        (memwb_rw),
    .regwen_mem   (exmem_regwen),
    .regwen_wb    (memwb_regwen),
    .memread_ex   (idex_memread),
    .branch_taken (branch_taken),
    .fwd_a        (fwd_a),
    .fwd_b        (fwd_b),
    .stall        (stall),
    .flush        (flush)
  );

  always_comb begin
    case (fwd_a)
      FROM_MEM: opnd_a = exmem_result;
      FROM_WB:  opnd_a = memwb_data;
      default:  opnd_a = idex_rdat1;
    endcase
    case (fwd_b)
      FROM_MEM: opnd_b = exmem_result;
      FROM_WB:  opnd_b = memwb_data;
      default:  opnd_b = idex_rdat2;
    endcase
  end

  // Forwarded rt is also the store data
  assign alu_b = idex_alusrc ? idex_imm : opnd_b;

  alu u_alu (
    .op     (idex_aluop),
    .port_a (opnd_a),
    .port_b (alu_b),
    .result (alu_out),
    .zero   (alu_zero)
  );

  assign branch_taken = idex_jump || (idex_beq && alu_zero) || (idex_bne && !alu_zero);
  assign target = idex_jump ? {idex_npc[31:28], idex_jidx, 2'b00}
                            : idex_npc + {idex_imm[29:0], 2'b00};

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      {exmem_regwen, exmem_memread, exmem_memwrite, exmem_halt} <= '0;
      exmem_rw     <= '0;
      memwb_regwen <= 1'b0;
      memwb_rw     <= '0;
    end else if (advance) begin
      {exmem_regwen, exmem_memread, exmem_memwrite, exmem_halt} <=
        {idex_regwen, idex_memread, idex_memwrite, idex_halt};
      exmem_rw     <= idex_rw;
      memwb_regwen <= exmem_regwen;
      memwb_rw     <= exmem_rw;
    end
  end

  always_ff @(posedge CLK) begin
    if (advance) begin
      exmem_result <= alu_out;
      exmem_store  <= opnd_b;
      memwb_data   <= exmem_memread ? load_word : exmem_result;
    end
  end

endmodule

// ==== verilog/memory_arbiter.sv ====
// Memory arbiter: one RAM port shared by fetch and data, data first, no preemption
`timescale 1ns/1ps

module memory_arbiter (
  input  logic             CLK,
  input  logic             nRST,
  input  logic             imem_ren,
  input  mem_pkg::addr_t   imem_addr,
  output isa_pkg::word_t   imem_load,
  output logic             ihit,
  input  logic             dmem_ren,
  input  logic             dmem_wen,
  input  mem_pkg::addr_t   dmem_addr,
  input  isa_pkg::word_t   dmem_store,
  output isa_pkg::word_t   dmem_load,
  output logic             dhit,
  output logic             ram_ren,
  output logic             ram_wen,
  output mem_pkg::addr_t   ram_addr,
  output isa_pkg::word_t   ram_store,
  input  isa_pkg::word_t   ram_load,
  input  logic             ram_ready
);
  import isa_pkg::*;
  import mem_pkg::*;

  arb_state_t state, next_state;
  logic       lat_ren, lat_wen;
  addr_t      lat_addr;
  word_t      lat_store;
  logic       data_req, busy;

  assign data_req = dmem_ren || dmem_wen;
  assign busy     = (state != IDLE);

  always_comb begin
    next_state = state;
    case (state)
      IDLE: begin
        if (data_req) begin
          next_state = DACCESS;
        end else if (imem_ren) begin
          next_state = IFETCH;
        end
      end
      // Hold until the memory answers, then rest in IDLE
      IFETCH, DACCESS: begin
        if (ram_ready) begin
          next_state = IDLE;
        end
      end
      default: next_state = IDLE;
    endcase
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      state   <= IDLE;
      lat_ren <= 1'b0;
      lat_wen <= 1'b0;
    end else begin
      state <= next_state;
      if (state == IDLE && data_req) begin
        lat_ren <= dmem_ren;
        lat_wen <= dmem_wen;
      end else if (state == IDLE && imem_ren) begin
        lat_ren <= 1'b1;
        lat_wen <= 1'b0;
      end
    end
  end

  // Address and store word captured with the grant
  always_ff @(posedge CLK) begin
    if (state == IDLE && data_req) begin
      lat_addr  <= dmem_addr;
      lat_store <= dmem_store;
    end else if (state == IDLE && imem_ren) begin
      lat_addr <= imem_addr;
    end
  end

  assign ram_ren   = busy && lat_ren;
  assign ram_wen   = busy && lat_wen;
  assign ram_addr  = lat_addr;
  assign ram_store = lat_store;

  // Completion goes only to the owner
  assign ihit      = (state == IFETCH) && ram_ready;
  assign dhit      = (state == DACCESS) && ram_ready;
  assign imem_load = ram_load;
  assign dmem_load = ram_load;

endmodule

// ==== verilog/hazard_unit.sv ====
// Hazard unit: operand forwarding selects, load-use stall, branch flush
`timescale 1ns/1ps

module hazard_unit (
  input  isa_pkg::regbits_t rs_dc,
  input  isa_pkg::regbits_t rt_dc,
  input  isa_pkg::regbits_t rs_ex,
  input  isa_pkg::regbits_t rt_ex,
  input  isa_pkg::regbits_t rw_mem,
  input  isa_pkg::regbits_t rw_wb,
  input  logic              regwen_mem,
  input  logic              regwen_wb,
  input  logic              memread_ex,
  input  logic              branch_taken,
  output isa_pkg::fwd_sel_t fwd_a,
  output isa_pkg::fwd_sel_t fwd_b,
  output logic              stall,
  output logic              flush
);
  import isa_pkg::*;

  // Youngest producer wins; register zero is never forwarded
  function automatic fwd_sel_t pick_src(input regbits_t src, input regbits_t rw_m,
                                        input logic wen_m, input regbits_t rw_w,
                                        input logic wen_w);
    if (wen_m && rw_m != '0 && rw_m == src) begin
      return FROM_MEM;
    end else if (wen_w && rw_w != '0 && rw_w == src) begin
      return FROM_WB;
    end
    return REGFILE;
  endfunction

  always_comb begin
    fwd_a = pick_src(rs_ex, rw_mem, regwen_mem, rw_wb, regwen_wb);
    fwd_b = pick_src(rt_ex, rw_mem, regwen_mem, rw_wb, regwen_wb);
  end

  // Load result is not ready until it leaves memory
  assign stall = memread_ex && (rt_ex != '0) && (rt_ex == rs_dc || rt_ex == rt_dc);

  // Predicted not taken, so a taken branch or jump kills fetch and decode
  assign flush = branch_taken;

endmodule

// ==== verilog/alu.sv ====
// Combinational ALU with zero flag for branch compare
`timescale 1ns/1ps

module alu (
  input  isa_pkg::alu_op_t op,
  input  isa_pkg::word_t   port_a,
  input  isa_pkg::word_t   port_b,
  output isa_pkg::word_t   result,
  output logic             zero
);
  import isa_pkg::*;

  always_comb begin
    case (op)
      ALU_ADD: result = port_a + port_b;
      ALU_SUB: result = port_a - port_b;
      ALU_AND: result = port_a & port_b;
      ALU_OR:  result = port_a | port_b;
      // Signed compare gives 0 or 1
      ALU_SLT: result = word_t'($signed(port_a) < $signed(port_b));
      // Immediate goes to the upper half
      ALU_LUI: result = {port_b[15:0], 16'h0000};
      default: result = '0;
    endcase
  end

  // BEQ and BNE run as a subtract
  assign zero = (result == '0);

endmodule

// ==== verilog/register_file.sv ====
// Register file with register zero tied to zero and write-before-read bypass
`timescale 1ns/1ps
`include "cpu_consts.svh"

module register_file (
  input  logic             CLK,
  input  logic             nRST,
  input  logic             wen,
  input  isa_pkg::regbits_t wsel,
  input  isa_pkg::word_t   wdat,
  input  isa_pkg::regbits_t rsel1,
  input  isa_pkg::regbits_t rsel2,
  output isa_pkg::word_t   rdat1,
  output isa_pkg::word_t   rdat2
);
  import isa_pkg::*;

  word_t regs [`REG_COUNT];
  logic  wr_live;

  // Register zero never takes a write
  assign wr_live = wen && (wsel != '0);

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      regs <= '{default: '0};
    end else if (wr_live) begin
      regs[wsel] <= wdat;
    end
  end

  // Same-cycle write shows up on the read ports
  assign rdat1 = (wr_live && wsel == rsel1) ? wdat : regs[rsel1];
  assign rdat2 = (wr_live && wsel == rsel2) ? wdat : regs[rsel2];

endmodule

// ==== verilog/mem_pkg.sv ====
// Memory-port types: byte address and arbiter states
`include "cpu_consts.svh"

package mem_pkg;

  typedef logic [`WORD_W-1:0] addr_t;

  // IDLE sits one cycle between accesses
  typedef enum logic [1:0] {
    IDLE,
    IFETCH,
    DACCESS
  } arb_state_t;

endpackage

// ==== verilog/isa_pkg.sv ====
// Instruction-set types: data word, register index, opcodes, function codes, ALU ops, operand sources
`include "cpu_consts.svh"

package isa_pkg;

  typedef logic [`WORD_W-1:0] word_t;
  typedef logic [$clog2(`REG_COUNT)-1:0] regbits_t;

  // Major opcodes, instruction bits 31:26
  typedef enum logic [5:0] {
    RTYPE = 6'h00,
    J     = 6'h02,
    BEQ   = 6'h04,
    BNE   = 6'h05,
    ADDIU = 6'h09,
    ORI   = 6'h0D,
    LUI   = 6'h0F,
    LW    = 6'h23,
    SW    = 6'h2B,
    HALT  = 6'h3F
  } opcode_t;

  // R-type function field, bits 5:0
  typedef enum logic [5:0] {
    ADDU = 6'h21,
    SUBU = 6'h23,
    AND  = 6'h24,
    OR   = 6'h25,
    SLT  = 6'h2A
  } funct_t;

  // ALU operations, prefixed so they stay apart from opcode and funct names
  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_SLT,
    ALU_LUI
  } alu_op_t;

  // Where an execute operand comes from
  typedef enum logic [1:0] {
    REGFILE,
    FROM_MEM,
    FROM_WB
  } fwd_sel_t;

endpackage

// ==== verilog/cpu_consts.svh ====
// Processor-wide constants: word width, register count, reset PC, halt encoding
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// Data and address width in bits
`define WORD_W 32

// Architectural registers, register zero included
`define REG_COUNT 32

// Program counter after reset
`define PC_INIT 32'h0000_0000

// Instruction word that stops the processor
// Its opcode field reads as HALT in the decoder
`define HALT_WORD 32'hFFFF_FFFF

`endif
